/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // Receiver clocks each bit with sixteen ticks of the oversampling counter
    localparam int OVERSAMPLE = 16;           // Ticks per serial bit
    localparam int MID_TICK   = 7;            // Tick index closest to the bit centre

    // Error flags that travel with every received word
    // Bit 2 is break, bit 1 is parity, bit 0 is frame
    typedef struct packed {
        logic brk;                            // Every sampled bit after the start bit was 0
        logic parity;                         // Received parity bit does not match even parity
        logic frame;                          // At least one stop bit was sampled low
    } rx_err_t;

    // Framer states, in the order a frame walks through them
    typedef enum logic [2:0] {
        IDLE,                                 // Line idle, waiting for a falling edge
        START,                                // Checking that the start bit is real
        DATA,                                 // Shifting in the data bits, MSB first
        PARITY,                               // Capturing the parity bit
        STOP,                                 // Checking the stop bits
        DONE                                  // One cycle to hand the word to the FIFO
    } framer_state_t;

endpackage

`default_nettype wire

/* rx_frame_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One received character on its way from the framer to the FIFO
interface rx_frame_if #(
    parameter int DATA_BITS = 8
) ();
    import uart_pkg::*;

    logic                 valid;          // Single cycle strobe, no back-pressure
    logic [DATA_BITS-1:0] data;           // Received data word, valid with the strobe
    rx_err_t              err;            // Break, parity and frame flags for that word
    logic                 busy;           // High from validated start bit to end of frame

    // The framer owns every signal of the frame
    modport framer (
        output valid,
        output data,
        output err,
        output busy
    );

    // The FIFO only listens
    modport sink (
        input valid,
        input data,
        input err,
        input busy
    );

endinterface

`default_nettype wire

/* rx_line_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_line_sync #(
    parameter int CLKS_PER_TICK = 4
) (
    input  logic Clk,
    input  logic Rst,
    input  logic rx,
    input  logic frame_restart,
    output logic rx_s,
    output logic tick
);

    // A divide by one still needs a one bit counter
    localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

    logic          rx_meta;              // First flop, may go metastable
    logic [CW-1:0] div_cnt;              // Clocks since the last tick

    // Two flop synchronizer for the asynchronous serial line
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_meta <= 1'b1;                 // Idle level of the line is high
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    // Oversampling tick, one pulse every CLKS_PER_TICK clocks
    // The framer restarts the divider on the falling edge of the start bit, so tick phase
    // is locked to the edge and the mid-bit sample lands near the centre of each bit
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (frame_restart) begin
            div_cnt <= '0;                   // Realign on the start edge
            tick    <= 1'b0;
        end else if (div_cnt == CW'(CLKS_PER_TICK - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;                 // Registered so the pulse is glitch free
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* uart_rx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_framer #(
    parameter int DATA_BITS = 8,
    parameter int STOP_BITS = 2
) (
    input  logic       Clk,
    input  logic       Rst,
    input  logic       rx_s,
    input  logic       tick,
    output logic       frame_restart,
    rx_frame_if.framer frm
);
    import uart_pkg::*;

    // Bit counter covers both the data bits and the stop bits
    localparam int MAX_BITS = (DATA_BITS > STOP_BITS) ? DATA_BITS : STOP_BITS;
    localparam int BW       = $clog2(MAX_BITS + 1);
    localparam logic [3:0] SAMPLE_TICK = 4'(MID_TICK);
    localparam logic [3:0] LAST_TICK   = 4'(OVERSAMPLE - 1);

    framer_state_t        state;
    logic [3:0]           phase;          // Tick index inside the current bit
    logic [BW-1:0]        bit_cnt;        // Data or stop bit index
    logic [DATA_BITS-1:0] shreg;          // Data shift register, MSB arrives first
    logic                 par_calc;       // Running XOR of the data bits
    logic                 par_rx;         // Parity bit as received
    logic                 stop_bad;       // Some stop bit was low
    logic                 seen_one;       // Some bit after the start bit was high
    logic                 busy_q;
    logic                 mid;            // Tick at the centre of the bit
    logic                 last;           // Final tick of the bit
    rx_err_t              err;

    assign mid  = tick && (phase == SAMPLE_TICK);
    assign last = tick && (phase == LAST_TICK);

    // A low line in IDLE is a candidate start edge, restart the tick divider on it
    assign frame_restart = (state == IDLE) && !rx_s;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state    <= IDLE;
            phase    <= '0;
            bit_cnt  <= '0;
            par_calc <= 1'b0;
            par_rx   <= 1'b0;
            stop_bad <= 1'b0;
            seen_one <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            if (tick) begin
                phase <= phase + 4'd1;           // Wraps from 15 to 0 at each bit boundary
            end
            case (state)
                IDLE: begin
                    phase   <= '0;
                    bit_cnt <= '0;
                    if (!rx_s) begin
                        state    <= START;
                        par_calc <= 1'b0;        // Fresh accumulators for the new frame
                        par_rx   <= 1'b0;
                        stop_bad <= 1'b0;
                        seen_one <= 1'b0;
                    end
                end
                START: begin
                    if (mid) begin
                        if (rx_s) begin
                            state <= IDLE;       // Line went back high, it was a glitch
                        end else begin
                            busy_q <= 1'b1;      // Start bit confirmed at its centre
                        end
                    end
                    if (last) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (mid) begin
                        par_calc <= par_calc ^ rx_s;
                        seen_one <= seen_one | rx_s;
                    end
                    if (last) begin
                        if (bit_cnt == BW'(DATA_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                PARITY: begin
                    if (mid) begin
                        par_rx   <= rx_s;
                        seen_one <= seen_one | rx_s;
                    end
                    if (last) begin
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (mid) begin
                        stop_bad <= stop_bad | !rx_s;
                        seen_one <= seen_one | rx_s;
                        // Leave at the centre of the last stop bit so the next start
                        // edge can be caught straight away
                        if (bit_cnt == BW'(STOP_BITS - 1)) begin
                            state <= DONE;
                        end
                    end
                    if (last) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DONE: begin
                    busy_q <= 1'b0;              // Frame finished
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data bits enter at the LSB and move up, so the first bit ends up as the MSB
    always_ff @(posedge Clk) begin
        if (state == DATA && mid) begin
            shreg <= (shreg << 1) | DATA_BITS'(rx_s);
        end
    end

    // Error flags are formed from the accumulators while in DONE
    always_comb begin
        err.brk    = !seen_one;                 // Data, parity and stops all low
        err.parity = (par_rx != par_calc);      // Even parity over the data bits
        err.frame  = stop_bad;
    end

    assign frm.valid = (state == DONE);
    assign frm.data  = shreg;
    assign frm.err   = err;
    assign frm.busy  = busy_q;

    // A word is handed over once per frame
    a_valid_single: assert property (@(posedge Clk) disable iff (Rst)
        frm.valid |=> !frm.valid);

    // The strobe follows the stop bit check directly
    a_valid_done: assert property (@(posedge Clk) disable iff (Rst)
        frm.valid |-> ($past(state) == STOP));

    a_idle_busy: assert property (@(posedge Clk) disable iff (Rst)
        (state == IDLE) |-> !frm.busy);

endmodule

`default_nettype wire

/* rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
    parameter int  FIFO_DEPTH = 8,
    parameter type payload_t  = logic [10:0]
) (
    input  logic     Clk,
    input  logic     Rst,
    rx_frame_if.sink wr,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     rd_valid,
    output logic     rts,
    output logic     overrun
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    payload_t      mem [FIFO_DEPTH];
    payload_t      wr_word;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;                  // Words currently stored
    logic          full;
    logic          empty;
    logic          push;
    logic          pop;

    // Data in the upper bits, error flags in the lowest three
    assign wr_word = payload_t'({wr.data, wr.err});

    assign full  = (count == CW'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = wr.valid && !full;      // Word is lost when there is no room
    assign pop   = rd_en && !empty;        // Reads of an empty FIFO do nothing

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither leave the fill alone
            endcase
            overrun <= wr.valid && full;        // One cycle pulse per dropped word
        end
    end

    // First word fall through, the head is visible as soon as it is stored
    assign rd_data  = mem[rd_ptr];
    assign rd_valid = !empty;

    // Ask the sender to pause before the last free slot is used
    assign rts = (count < CW'(FIFO_DEPTH - 1));

    a_count_max: assert property (@(posedge Clk) disable iff (Rst)
        count <= CW'(FIFO_DEPTH));

    // The read side never moves while nothing is stored
    a_no_pop_empty: assert property (@(posedge Clk) disable iff (Rst)
        empty |=> $stable(rd_ptr));

    // A dropped word must come from a frame the framer actually received
    a_overrun_busy: assert property (@(posedge Clk) disable iff (Rst)
        overrun |-> $past(wr.busy));

endmodule

`default_nettype wire

/* uart_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top #(
    parameter int DATA_BITS     = 8,
    parameter int STOP_BITS     = 2,
    parameter int CLKS_PER_TICK = 4,
    parameter int FIFO_DEPTH    = 8
) (
    input  logic                 Clk,
    input  logic                 Rst,
    input  logic                 rx,
    input  logic                 rd_en,
    output logic [DATA_BITS-1:0] rd_data,
    output logic [2:0]           rd_err,
    output logic                 rd_valid,
    output logic                 rts,
    output logic                 overrun
);
    import uart_pkg::*;

    // One FIFO entry is the data word plus its error flags
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        rx_err_t              err;
    } rx_word_t;

    logic     rx_s;                        // Synchronized serial line
    logic     tick;                        // 16x oversampling pulse
    logic     frame_restart;               // Realigns the tick on a start edge
    rx_word_t head;                        // Word at the FIFO output

    rx_frame_if #(.DATA_BITS(DATA_BITS)) frame_if ();

    rx_line_sync #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) u_sync (
        .Clk           (Clk),
        .Rst           (Rst),
        .rx            (rx),
        .frame_restart (frame_restart),
        .rx_s          (rx_s),
        .tick          (tick)
    );

    uart_rx_framer #(
        .DATA_BITS(DATA_BITS),
        .STOP_BITS(STOP_BITS)
    ) u_framer (
        .Clk           (Clk),
        .Rst           (Rst),
        .rx_s          (rx_s),
        .tick          (tick),
        .frame_restart (frame_restart),
        .frm           (frame_if.framer)
    );

    rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .payload_t (rx_word_t)
    ) u_fifo (
        .Clk      (Clk),
        .Rst      (Rst),
        .wr       (frame_if.sink),
        .rd_en    (rd_en),
        .rd_data  (head),
        .rd_valid (rd_valid),
        .rts      (rts),
        .overrun  (overrun)
    );

    assign rd_data = head.data;
    assign rd_err  = head.err;              // Break, parity, frame from MSB down

endmodule

`default_nettype wire

/* tb_uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;
    import uart_pkg::*;

    localparam int DATA_BITS     = 8;           // Same values as the DUT defaults
    localparam int STOP_BITS     = 2;
    localparam int CLKS_PER_TICK = 4;
    localparam int FIFO_DEPTH    = 8;
    localparam int BIT_CLKS      = OVERSAMPLE * CLKS_PER_TICK;
    // Start, data, parity, stops and one idle bit after every frame
    localparam int FRAME_CLKS    = BIT_CLKS * (DATA_BITS + STOP_BITS + 3);

    // One word as it should leave the FIFO
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        rx_err_t              err;
    } exp_word_t;

    logic                 Clk     = 1'b0;
    logic                 Rst     = 1'b1;
    logic                 rx      = 1'b1;   // Line idles high
    logic                 rd_en   = 1'b0;
    logic [DATA_BITS-1:0] rd_data;
    logic [2:0]           rd_err;
    logic                 rd_valid;
    logic                 rts;
    logic                 overrun;

    exp_word_t            exp_q [$];        // Words still expected at the FIFO output
    logic [DATA_BITS-1:0] stored [FIFO_DEPTH+1];
    logic                 reading = 1'b0;   // Compare process may pop the FIFO
    int                   overrun_cnt = 0;  // Overrun pulses seen so far
    integer               seed;

    uart_rx_top #(
        .DATA_BITS     (DATA_BITS),
        .STOP_BITS     (STOP_BITS),
        .CLKS_PER_TICK (CLKS_PER_TICK),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_dut (
        .Clk      (Clk),
        .Rst      (Rst),
        .rx       (rx),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .rd_err   (rd_err),
        .rd_valid (rd_valid),
        .rts      (rts),
        .overrun  (overrun)
    );

    always #50 Clk = ~Clk;                   // 100 ns period

    // Prints the failure verdict and ends the run
    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    // Holds one level on the line for a whole bit time
    task automatic drive_bit(input logic level);
        @(posedge Clk);
        rx <= level;
        repeat (BIT_CLKS - 1) @(posedge Clk);
    endtask

    // Start bit, data MSB first, even parity, stop bits, then one idle bit
    task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic flip_parity,
                              input logic [STOP_BITS-1:0] stop_low);
        drive_bit(1'b0);
        for (int i = DATA_BITS - 1; i >= 0; i--) begin
            drive_bit(data[i]);
        end
        drive_bit((^data) ^ flip_parity);   // Inverted parity on request
        for (int i = 0; i < STOP_BITS; i++) begin
            drive_bit(!stop_low[i]);         // A set mask bit pulls that stop bit low
        end
        drive_bit(1'b1);
    endtask

    // Expected word from the framing rules
    function automatic exp_word_t expected_word(input logic [DATA_BITS-1:0] data,
                                                input logic flip_parity,
                                                input logic [STOP_BITS-1:0] bad_stop);
        exp_word_t w;
        logic      par_bit;
        par_bit      = (^data) ^ flip_parity;          // Parity bit as it is on the line
        w.data       = data;
        w.err.parity = (par_bit != (^data));
        w.err.frame  = (bad_stop != '0);
        // Break needs every sampled bit after the start bit low
        w.err.brk    = (data == '0) && !par_bit && (bad_stop == '1);
        return w;
    endfunction

    task automatic send_checked(input logic [DATA_BITS-1:0] data, input logic flip_parity,
                                input logic [STOP_BITS-1:0] stop_low);
        exp_q.push_back(expected_word(data, flip_parity, stop_low));
        send_frame(data, flip_parity, stop_low);
    endtask

    // Waits until every expected word has been read back
    task automatic wait_queue_empty(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge Clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for rd_valid, %0d words never arrived", exp_q.size());
            abort_run();
        end
    endtask

    // Pops every other cycle while allowed, and checks each popped head
    always @(posedge Clk) begin
        exp_word_t want;
        if (Rst) begin
            rd_en <= 1'b0;
        end else begin
            if (rd_en && rd_valid) begin     // A real pop happens at this edge
                if (exp_q.size() == 0) begin
                    $display("a word came out of the FIFO although none was expected");
                    abort_run();
                end else begin
                    want = exp_q.pop_front();
                    assert (rd_data == want.data) else begin
                        $display("Fail rd_data got %h expected %h", rd_data, want.data);
                        abort_run();
                    end
                    assert (rd_err == want.err) else begin
                        $display("Fail rd_err got %h expected %h", rd_err, want.err);
                        abort_run();
                    end
                end
            end
            rd_en <= reading && rd_valid && !rd_en;
        end
    end

    always @(posedge Clk) begin
        if (!Rst && overrun) begin
            overrun_cnt <= overrun_cnt + 1;
        end
    end

    initial begin
        int k;
        int n;
        int fill;
        int ovr_base;
        seed = 32'hd0fa0c10;
        repeat (16) @(posedge Clk);
        Rst     <= 1'b0;
        reading <= 1'b1;

        // Clean bytes come out in order with no error flags
        for (k = 0; k < 20; k++) begin
            send_checked(DATA_BITS'($random(seed)), 1'b0, '0);
        end
        wait_queue_empty(2 * FRAME_CLKS);

        send_checked(DATA_BITS'($random(seed)), 1'b1, '0);       // Parity flag only
        send_checked(DATA_BITS'($random(seed)), 1'b0, STOP_BITS'(2));  // Second stop low
        send_checked('0, 1'b0, '1);                               // Line low the whole frame
        wait_queue_empty(2 * FRAME_CLKS);

        // Quarter bit glitch must not start a frame
        @(posedge Clk);
        rx <= 1'b0;
        repeat (BIT_CLKS / 4) @(posedge Clk);
        rx <= 1'b1;
        for (n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge Clk);
            assert (!rd_valid) else begin
                $display("Fail rd_valid got %h expected %h", rd_valid, 1'b0);
                abort_run();
            end
        end
        send_checked(DATA_BITS'($random(seed)), 1'b0, '0);
        wait_queue_empty(2 * FRAME_CLKS);

        // Fill the FIFO with reads stopped, one byte more than it holds
        @(posedge Clk);
        reading  <= 1'b0;
        ovr_base = overrun_cnt;
        for (k = 0; k <= FIFO_DEPTH; k++) begin
            stored[k] = DATA_BITS'($random(seed));
            send_frame(stored[k], 1'b0, '0);
            @(negedge Clk);
            fill = (k + 1 < FIFO_DEPTH) ? k + 1 : FIFO_DEPTH;
            assert (rts == (fill < FIFO_DEPTH - 1)) else begin
                $display("Fail rts got %h expected %h", rts, fill < FIFO_DEPTH - 1);
                abort_run();
            end
            assert (overrun_cnt - ovr_base == ((k == FIFO_DEPTH) ? 1 : 0)) else begin
                $display("Fail overrun got %h expected %h", overrun_cnt - ovr_base,
                         (k == FIFO_DEPTH) ? 1 : 0);
                abort_run();
            end
        end

        // Only the first FIFO_DEPTH bytes are stored, the last one was dropped
        for (k = 0; k < FIFO_DEPTH; k++) begin
            exp_q.push_back(expected_word(stored[k], 1'b0, '0));
        end
        @(posedge Clk);
        reading <= 1'b1;
        n = 0;
        while (exp_q.size() != 0 && n < 8 * FIFO_DEPTH) begin
            @(negedge Clk);
            // Queue length equals the fill here, rts must follow it
            assert (rts == (exp_q.size() < FIFO_DEPTH - 1)) else begin
                $display("Fail rts got %h expected %h", rts, exp_q.size() < FIFO_DEPTH - 1);
                abort_run();
            end
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout waiting for rd_valid while draining the full FIFO");
            abort_run();
        end

        repeat (4) @(posedge Clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
uart_pkg.sv
rx_frame_if.sv
rx_line_sync.sv
uart_rx_framer.sv
rx_fifo.sv
uart_rx_top.sv
tb_uart_rx.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_uart_rx
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

# Build and run, then decide the verdict from the log
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
